// File: source/tage_pkg.sv
package tage_pkg;

	localparam int ADDR_W = 32;
	localparam int GHR_W = 16;
	localparam int NUM_TAGGED = 2;
	localparam int NUM_PROV = 3;   // Provider 0 is the base table
	localparam int BASE_IDX_W = 8;
	localparam int TBL_IDX_W = 6;
	localparam int TAG_W = 8;

	// Entry 0 is table 1, entry 1 is table 2
	localparam logic [NUM_TAGGED-1:0][4:0] HIST_LEN = {5'd12, 5'd4};

	localparam int CTR_W = 3;
	localparam logic [CTR_W-1:0] CTR_WEAK_T = 3'd4;
	localparam logic [CTR_W-1:0] CTR_WEAK_NT = 3'd3;
	localparam int U_W = 2;
	localparam logic [1:0] BASE_CTR_INIT = 2'd2;   // Weakly taken

	typedef logic [1:0] prov_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [CTR_W-1:0] ctr;
		logic [U_W-1:0]   u;
	} tag_entry_t;

	typedef struct packed {
		logic [BASE_IDX_W-1:0]                base_idx;
		logic [NUM_TAGGED-1:0][TBL_IDX_W-1:0] idx;
		logic [NUM_TAGGED-1:0][TAG_W-1:0]     tag;
	} lookup_t;

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic [GHR_W-1:0]  ghr;
	} req_t;

	typedef struct packed {
		lookup_t           lookup;
		logic [ADDR_W-1:0] pc;
	} req_hashed_t;

	typedef struct packed {
		prov_t provider;
		logic  alt_pred;
		logic  prov_pred;
	} meta_t;

	typedef struct packed {
		logic              pred;
		meta_t             meta;
		logic [ADDR_W-1:0] pc;
	} resp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic [GHR_W-1:0]  ghr;
		logic              outcome;   // 1 is taken
		meta_t             meta;
	} fb_t;

endpackage

// File: source/tage_index_hash.sv
`timescale 1ns/1ns

module tage_index_hash (
	input  logic [tage_pkg::ADDR_W-1:0] i_pc,
	input  logic [tage_pkg::GHR_W-1:0]  i_ghr,
	output tage_pkg::lookup_t           o_lookup
);
	import tage_pkg::*;

	logic [TBL_IDX_W-1:0] idx_fold;
	logic [TAG_W-1:0]     tag_fold;

	always_comb
	begin
		o_lookup.base_idx = i_pc[2 +: BASE_IDX_W];
		for (int t = 0; t < NUM_TAGGED; t++)
		begin
			idx_fold = '0;
			tag_fold = '0;
			// Only the newest HIST_LEN bits take part, upper chunks end zero padded
			for (int b = 0; b < GHR_W; b++)
			begin
				if (b < int'(HIST_LEN[t]))
				begin
					idx_fold[b % TBL_IDX_W] = idx_fold[b % TBL_IDX_W] ^ i_ghr[b];
					tag_fold[b % TAG_W] = tag_fold[b % TAG_W] ^ i_ghr[b];
				end
			end
			o_lookup.idx[t] = i_pc[2 +: TBL_IDX_W] ^ idx_fold;
			o_lookup.tag[t] = i_pc[8 +: TAG_W] ^ tag_fold;
		end
	end

endmodule

// File: source/tage_pipe_reg.sv
`timescale 1ns/1ns

module tage_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t i_data,
	input  logic     i_valid,
	output logic     o_ready,
	output payload_t o_data,
	output logic     o_valid,
	input  logic     i_ready
);

	// Free slot, or the held item leaves on this edge
	assign o_ready = i_ready || !o_valid;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			o_valid <= 1'b0;
		else if (o_ready)
			o_valid <= i_valid;
	end

	always_ff @(posedge clk)
	begin
		if (o_ready && i_valid)
			o_data <= i_data;
	end

endmodule

// File: source/tage_base_table.sv
`timescale 1ns/1ns

module tage_base_table (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [tage_pkg::BASE_IDX_W-1:0] i_rd_idx,
	output logic [1:0]                      o_rd_ctr,
	input  logic [tage_pkg::BASE_IDX_W-1:0] i_up_idx,
	output logic [1:0]                      o_up_ctr,
	input  logic                            i_wr_en,
	input  logic [1:0]                      i_wr_ctr
);
	import tage_pkg::*;

	logic [1:0] ctr_mem [2**BASE_IDX_W];

	assign o_rd_ctr = ctr_mem[i_rd_idx];   // Prediction lookup
	assign o_up_ctr = ctr_mem[i_up_idx];

	// Writes always target the feedback index
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ctr_mem <= '{default: BASE_CTR_INIT};
		else if (i_wr_en)
			ctr_mem[i_up_idx] <= i_wr_ctr;
	end

endmodule

// File: source/tage_tagged_table.sv
`timescale 1ns/1ns

module tage_tagged_table (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [tage_pkg::TBL_IDX_W-1:0] i_rd_idx,
	output tage_pkg::tag_entry_t           o_rd_entry,
	input  logic [tage_pkg::TBL_IDX_W-1:0] i_up_idx,
	output tage_pkg::tag_entry_t           o_up_entry,
	input  logic                           i_wr_en,
	input  tage_pkg::tag_entry_t           i_wr_entry
);
	import tage_pkg::*;

	logic             valid_mem [2**TBL_IDX_W];
	logic [TAG_W-1:0] tag_mem [2**TBL_IDX_W];
	logic [CTR_W-1:0] ctr_mem [2**TBL_IDX_W];
	logic [U_W-1:0]   u_mem [2**TBL_IDX_W];

	// Lookup port
	always_comb
	begin
		o_rd_entry.valid = valid_mem[i_rd_idx];
		o_rd_entry.tag = tag_mem[i_rd_idx];
		o_rd_entry.ctr = ctr_mem[i_rd_idx];
		o_rd_entry.u = u_mem[i_rd_idx];
	end

	// Update read, same index as the write
	always_comb
	begin
		o_up_entry.valid = valid_mem[i_up_idx];
		o_up_entry.tag = tag_mem[i_up_idx];
		o_up_entry.ctr = ctr_mem[i_up_idx];
		o_up_entry.u = u_mem[i_up_idx];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_mem <= '{default: 1'b0};
			ctr_mem <= '{default: CTR_WEAK_T};
			u_mem <= '{default: '0};
		end
		else if (i_wr_en)
		begin
			valid_mem[i_up_idx] <= i_wr_entry.valid;
			ctr_mem[i_up_idx] <= i_wr_entry.ctr;
			u_mem[i_up_idx] <= i_wr_entry.u;
		end
	end

	// Tag is meaningless while the entry is invalid
	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			tag_mem[i_up_idx] <= i_wr_entry.tag;
	end

endmodule

// File: source/tage_provider_select.sv
`timescale 1ns/1ns

module tage_provider_select (
	input  tage_pkg::req_hashed_t                          i_hashed,
	input  logic [1:0]                                     i_base_ctr,
	input  tage_pkg::tag_entry_t [tage_pkg::NUM_TAGGED-1:0] i_entries,
	output tage_pkg::resp_t                                o_resp
);
	import tage_pkg::*;

	logic [NUM_TAGGED-1:0] hit;
	logic [NUM_PROV-1:0]   pred_of;
	prov_t                 prov;
	prov_t                 alt;

	always_comb
	begin
		pred_of[0] = i_base_ctr[1];   // 2 or more is taken
		for (int t = 0; t < NUM_TAGGED; t++)
		begin
			hit[t] = i_entries[t].valid && (i_entries[t].tag == i_hashed.lookup.tag[t]);
			pred_of[t + 1] = i_entries[t].ctr[CTR_W-1];
		end
	end

	// Walk upward so the last hit wins and the one before it is the alternate
	always_comb
	begin
		prov = '0;
		alt = '0;
		for (int t = 0; t < NUM_TAGGED; t++)
		begin
			if (hit[t])
			begin
				alt = prov;
				prov = prov_t'(t + 1);
			end
		end
	end

	always_comb
	begin
		o_resp.pred = pred_of[prov];
		o_resp.meta.provider = prov;
		o_resp.meta.alt_pred = pred_of[alt];
		o_resp.meta.prov_pred = pred_of[prov];
		o_resp.pc = i_hashed.pc;
	end

endmodule

// File: source/tage_update_ctrl.sv
`timescale 1ns/1ns

module tage_update_ctrl (
	input  tage_pkg::fb_t                                  i_fb,
	input  logic                                           i_fb_valid,
	input  tage_pkg::lookup_t                              i_lookup,
	input  logic [1:0]                                     i_base_ctr,
	input  tage_pkg::tag_entry_t [tage_pkg::NUM_TAGGED-1:0] i_entries,
	output logic                                           o_base_wr_en,
	output logic [1:0]                                     o_base_ctr,
	output logic [tage_pkg::NUM_TAGGED-1:0]                o_tbl_wr_en,
	output tage_pkg::tag_entry_t [tage_pkg::NUM_TAGGED-1:0] o_tbl_entry
);
	import tage_pkg::*;

	prov_t prov;
	logic  mispred;
	logic  alloc_req;
	logic  alloc_done;

	function automatic logic [CTR_W-1:0] ctr_step(input logic [CTR_W-1:0] c, input logic up);
		ctr_step = c;
		if (up && (c != '1))
			ctr_step = c + 1'b1;
		else if (!up && (c != '0))
			ctr_step = c - 1'b1;
	endfunction

	assign prov = i_fb.meta.provider;
	assign mispred = i_fb.meta.prov_pred != i_fb.outcome;
	assign alloc_req = mispred && (int'(prov) < NUM_TAGGED);   // Only below the top table

	// Base trains only as provider
	always_comb
	begin
		o_base_wr_en = i_fb_valid && (prov == '0);
		o_base_ctr = i_base_ctr;
		if (i_fb.outcome && (i_base_ctr != 2'd3))
			o_base_ctr = i_base_ctr + 2'd1;
		else if (!i_fb.outcome && (i_base_ctr != 2'd0))
			o_base_ctr = i_base_ctr - 2'd1;
	end

	always_comb
	begin
		alloc_done = 1'b0;
		for (int t = 0; t < NUM_TAGGED; t++)
		begin
			o_tbl_entry[t] = i_entries[t];
			o_tbl_wr_en[t] = 1'b0;
			if (int'(prov) == t + 1)
			begin
				o_tbl_entry[t].ctr = ctr_step(i_entries[t].ctr, i_fb.outcome);
				if (i_fb.meta.alt_pred != i_fb.meta.prov_pred)
				begin
					if (!mispred && (i_entries[t].u != '1))
						o_tbl_entry[t].u = i_entries[t].u + 1'b1;
					else if (mispred && (i_entries[t].u != '0))
						o_tbl_entry[t].u = i_entries[t].u - 1'b1;
				end
				o_tbl_wr_en[t] = i_fb_valid;
			end
			else if (alloc_req && !alloc_done && ((t + 1) > int'(prov)) &&
				(!i_entries[t].valid || (i_entries[t].u == '0)))
			begin
				o_tbl_entry[t] = '{valid: 1'b1, tag: i_lookup.tag[t],
					ctr: (i_fb.outcome ? CTR_WEAK_T : CTR_WEAK_NT), u: '0};
				o_tbl_wr_en[t] = i_fb_valid;
				alloc_done = 1'b1;
			end
		end
		// Every candidate is still useful, so age them all
		if (alloc_req && !alloc_done)
		begin
			for (int t = 0; t < NUM_TAGGED; t++)
			begin
				if ((t + 1) > int'(prov))
				begin
					o_tbl_entry[t].u = i_entries[t].u - 1'b1;
					o_tbl_wr_en[t] = i_fb_valid;
				end
			end
		end
	end

endmodule

// File: source/tage_predictor.sv
`timescale 1ns/1ns

module tage_predictor (
	input  logic              clk,
	input  logic              rst_n,
	input  tage_pkg::req_t    i_req,
	input  logic              i_req_valid,
	output logic              o_req_ready,
	output tage_pkg::resp_t   o_resp,
	output logic              o_resp_valid,
	input  logic              i_resp_ready,
	input  tage_pkg::fb_t     i_fb,
	input  logic              i_fb_valid
);
	import tage_pkg::*;

	lookup_t     req_lookup;
	lookup_t     fb_lookup;
	req_hashed_t a_in;
	req_hashed_t a_out;
	logic        a_valid;
	logic        b_ready;
	resp_t       b_in;

	logic [1:0] base_rd_ctr;
	logic [1:0] base_up_ctr;
	logic [1:0] base_wr_ctr;
	logic       base_wr_en;

	tag_entry_t [NUM_TAGGED-1:0] rd_entries;
	tag_entry_t [NUM_TAGGED-1:0] up_entries;
	tag_entry_t [NUM_TAGGED-1:0] wr_entries;
	logic [NUM_TAGGED-1:0]       tbl_wr_en;

	tage_index_hash u_req_hash (
		.i_pc(i_req.pc),
		.i_ghr(i_req.ghr),
		.o_lookup(req_lookup)
	);

	assign a_in = '{lookup: req_lookup, pc: i_req.pc};

	tage_pipe_reg #(.payload_t(req_hashed_t)) u_stage_a (
		.clk,
		.rst_n,
		.i_data(a_in),
		.i_valid(i_req_valid),
		.o_ready(o_req_ready),
		.o_data(a_out),
		.o_valid(a_valid),
		.i_ready(b_ready)
	);

	tage_base_table u_base (
		.clk,
		.rst_n,
		.i_rd_idx(a_out.lookup.base_idx),
		.o_rd_ctr(base_rd_ctr),
		.i_up_idx(fb_lookup.base_idx),
		.o_up_ctr(base_up_ctr),
		.i_wr_en(base_wr_en),
		.i_wr_ctr(base_wr_ctr)
	);

	for (genvar t = 0; t < NUM_TAGGED; t++)
	begin : g_tbl
		tage_tagged_table u_tbl (
			.clk,
			.rst_n,
			.i_rd_idx(a_out.lookup.idx[t]),
			.o_rd_entry(rd_entries[t]),
			.i_up_idx(fb_lookup.idx[t]),
			.o_up_entry(up_entries[t]),
			.i_wr_en(tbl_wr_en[t]),
			.i_wr_entry(wr_entries[t])
		);
	end

	tage_provider_select u_select (
		.i_hashed(a_out),
		.i_base_ctr(base_rd_ctr),
		.i_entries(rd_entries),
		.o_resp(b_in)
	);

	tage_pipe_reg #(.payload_t(resp_t)) u_stage_b (
		.clk,
		.rst_n,
		.i_data(b_in),
		.i_valid(a_valid),
		.o_ready(b_ready),
		.o_data(o_resp),
		.o_valid(o_resp_valid),
		.i_ready(i_resp_ready)
	);

	// Feedback recomputes indices from its own pc and history
	tage_index_hash u_fb_hash (
		.i_pc(i_fb.pc),
		.i_ghr(i_fb.ghr),
		.o_lookup(fb_lookup)
	);

	tage_update_ctrl u_update (
		.i_fb,
		.i_fb_valid,
		.i_lookup(fb_lookup),
		.i_base_ctr(base_up_ctr),
		.i_entries(up_entries),
		.o_base_wr_en(base_wr_en),
		.o_base_ctr(base_wr_ctr),
		.o_tbl_wr_en(tbl_wr_en),
		.o_tbl_entry(wr_entries)
	);

endmodule

// File: dv/tage_tb.sv
`timescale 1ns/1ns

module tage_tb;
	import tage_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int TIMEOUT = 50;
	localparam logic [31:0] SEED = 32'd75417;
	localparam int FIELDS = 7;   // pc ghr outcome pred provider stall feedback
	localparam int MAX_LINES = 64;
	localparam logic [31:0] END_PC = 32'hffff_ffff;

	logic  clk;
	logic  rst_n;
	req_t  i_req;
	logic  i_req_valid;
	logic  o_req_ready;
	resp_t o_resp;
	logic  o_resp_valid;
	logic  i_resp_ready;
	fb_t   i_fb;
	logic  i_fb_valid;

	logic [31:0] trace_mem [FIELDS*MAX_LINES];
	logic [31:0] lcg_state;
	int          check_count;
	int          mismatch_count;
	int          fault_count;

	tage_predictor DUT (
		.clk,
		.rst_n,
		.i_req,
		.i_req_valid,
		.o_req_ready,
		.o_resp,
		.o_resp_valid,
		.i_resp_ready,
		.i_fb,
		.i_fb_valid
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] trace_field(input int row, input int col);
		return trace_mem[row * FIELDS + col];
	endfunction

	function logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task check_value(input logic [63:0] actual, input logic [63:0] expected, input string what);
		check_count++;
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
		end
	endtask

	task report_and_finish();
		$display("Checks run: %0d, mismatches: %0d, other failures: %0d", check_count,
			mismatch_count, fault_count);
		if ((mismatch_count == 0) && (fault_count == 0))
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task abort_run(input string what);
		fault_count++;
		$display("Timeout at %0t ns while %s", $time, what);
		report_and_finish();
	endtask

	// Returns on the edge where the request is taken
	task automatic send_request(input logic [31:0] pc, input logic [15:0] ghr, output int waited);
		waited = 0;
		i_req <= '{pc: pc, ghr: ghr};
		i_req_valid <= 1'b1;
		@(negedge clk);
		while (!o_req_ready)
		begin
			if (waited >= TIMEOUT)
				abort_run("waiting for o_req_ready");
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		i_req_valid <= 1'b0;
	endtask

	task automatic receive_response(output resp_t resp);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!o_resp_valid)
		begin
			if (waited >= TIMEOUT)
				abort_run("waiting for o_resp_valid");
			@(negedge clk);
			waited++;
		end
		resp = o_resp;
		@(posedge clk);   // Taken here while i_resp_ready is high
	endtask

	// Back-pressure with only stage B occupied
	task automatic hold_response(input int cycles);
		resp_t held;
		int    waited;
		waited = 0;
		@(negedge clk);
		while (!o_resp_valid)
		begin
			if (waited >= TIMEOUT)
				abort_run("waiting for a stalled response");
			@(negedge clk);
			waited++;
		end
		held = o_resp;
		repeat (cycles)
		begin
			@(negedge clk);
			check_value(64'(o_resp_valid), 64'(1), "o_resp_valid under back-pressure");
			check_value(64'(o_resp), 64'(held), "o_resp payload under back-pressure");
			check_value(64'(o_req_ready), 64'(1), "o_req_ready with one stage full");
		end
		@(posedge clk);
		i_resp_ready <= 1'b1;
	endtask

	task automatic check_response(input int row, input resp_t resp);
		check_value(64'(resp.pc), 64'(trace_field(row, 0)), $sformatf("line %0d pc", row + 1));
		check_value(64'(resp.pred), 64'(trace_field(row, 3)),
			$sformatf("line %0d prediction", row + 1));
		check_value(64'(resp.meta.prov_pred), 64'(trace_field(row, 3)),
			$sformatf("line %0d provider prediction", row + 1));
		check_value(64'(resp.meta.provider), 64'(trace_field(row, 4)),
			$sformatf("line %0d provider", row + 1));
	endtask

	task automatic drive_feedback(input int row, input meta_t meta);
		i_fb.pc <= trace_field(row, 0);
		i_fb.ghr <= 16'(trace_field(row, 1));
		i_fb.outcome <= (trace_field(row, 2) != 0);
		i_fb.meta <= meta;
		i_fb_valid <= 1'b1;
		@(posedge clk);   // Tables written on this edge
		i_fb_valid <= 1'b0;
	endtask

	task automatic run_line(input int row);
		resp_t resp;
		int    waited;
		if (trace_field(row, 5) == 1)
			i_resp_ready <= 1'b0;
		send_request(trace_field(row, 0), 16'(trace_field(row, 1)), waited);
		if (trace_field(row, 5) == 1)
			hold_response(1 + int'((next_random() >> 16) % 6));
		receive_response(resp);
		check_response(row, resp);
		if (trace_field(row, 6) != 0)
			drive_feedback(row, resp.meta);
	endtask

	// Two requests in flight before either response is taken
	task automatic run_pair(input int row);
		resp_t first;
		resp_t second;
		resp_t held;
		int    waited;
		int    cycles;
		cycles = 1 + int'((next_random() >> 16) % 6);
		i_resp_ready <= 1'b0;
		send_request(trace_field(row, 0), 16'(trace_field(row, 1)), waited);
		send_request(trace_field(row + 1, 0), 16'(trace_field(row + 1, 1)), waited);
		check_value(64'(waited), 64'(0), "wait of the second request with stage B empty");
		@(negedge clk);
		check_value(64'(o_resp_valid), 64'(1), "o_resp_valid with both stages full");
		held = o_resp;
		repeat (cycles)
		begin
			check_value(64'(o_req_ready), 64'(0), "o_req_ready with both stages full");
			@(negedge clk);
			check_value(64'(o_resp), 64'(held), "payload of the held response");
		end
		@(posedge clk);
		i_resp_ready <= 1'b1;
		receive_response(first);
		receive_response(second);
		check_response(row, first);
		check_response(row + 1, second);
		if (trace_field(row, 6) != 0)
			drive_feedback(row, first.meta);
		if (trace_field(row + 1, 6) != 0)
			drive_feedback(row + 1, second.meta);
	endtask

	initial
	begin
		int row;
		rst_n = 1'b0;
		i_req = '0;
		i_req_valid = 1'b0;
		i_resp_ready = 1'b1;
		i_fb = '0;
		i_fb_valid = 1'b0;
		check_count = 0;
		mismatch_count = 0;
		fault_count = 0;
		lcg_state = SEED;
		$readmemh("dv/tage_trace.txt", trace_mem);

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value(64'(o_resp_valid), 64'(0), "o_resp_valid after reset");
		check_value(64'(o_req_ready), 64'(1), "o_req_ready after reset");
		@(posedge clk);

		row = 0;
		while ((row < MAX_LINES) && !$isunknown(trace_field(row, 0)) &&
			(trace_field(row, 0) != END_PC))
		begin
			if (trace_field(row, 5) == 2)
			begin
				run_pair(row);
				row += 2;
			end
			else
			begin
				run_line(row);
				row++;
			end
		end
		if ((row == 0) || (trace_field(row, 0) !== END_PC))
		begin
			fault_count++;
			$display("The trace file is missing, empty or lacks its end marker line");
		end
		report_and_finish();
	end

endmodule

// File: build.f
source/tage_pkg.sv
source/tage_index_hash.sv
source/tage_pipe_reg.sv
source/tage_base_table.sv
source/tage_tagged_table.sv
source/tage_provider_select.sv
source/tage_update_ctrl.sv
source/tage_predictor.sv
dv/tage_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tage_tb -f build.f -o Vtage_tb
./obj_dir/Vtage_tb > sim.log 2>&1
cat sim.log
if grep -qx "No errors" sim.log
then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: dv/tage_trace.txt
// Columns: pc ghr outcome expected_pred expected_provider stall feedback (hex)
// Stall 1 holds i_resp_ready low, stall 2 pairs the line with the next one
00001100 0000 0 1 0 0 1
00001100 0001 0 0 0 0 1
// Base miss allocated table 1, which now mispredicts and allocates table 2
00001100 0000 1 0 1 0 1
00001100 0000 1 1 2 1 1
// Table 2 misses on other history, back to back
00001100 0010 1 1 1 2 0
00001100 0003 0 0 0 0 0
// Second branch builds a useful table 2 entry
00002220 0000 0 1 0 0 1
00002220 0000 1 0 1 0 1
00002220 0000 0 1 2 0 1
00002220 0000 0 0 2 1 1
00002220 0000 0 0 2 0 1
// Same table 2 slot, other tag, ages twice and then allocates
00002220 0c30 0 1 1 0 1
00002220 0c30 1 0 1 0 1
00002220 0c30 0 1 1 0 1
00002220 0c30 0 0 2 0 1
00002220 0000 1 0 1 1 0
ffffffff 0000 0 0 0 0 0
